//--- hdl/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

   // processor address split as tag | index | offset
   localparam int ADDR_W   = 16;
   localparam int TAG_W    = 7;
   localparam int INDEX_W  = 5;
   localparam int OFFSET_W = 4;

   // line geometry
   localparam int LINE_BYTES = 16;
   localparam int NUM_LINES  = 32;
   localparam int LINE_W     = LINE_BYTES * 8;

   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [TAG_W-1:0]    tag_t;
   typedef logic [INDEX_W-1:0]  index_t;
   typedef logic [OFFSET_W-1:0] offset_t;

   // one full cache line, byte 0 in bits 7:0
   typedef logic [LINE_W-1:0] line_t;

   // one enable per byte lane
   typedef logic [LINE_BYTES-1:0] byte_mask_t;

endpackage

`default_nettype wire

//--- hdl/cache_bus_pkg.sv
`default_nettype none

package cache_bus_pkg;

   // access size, encoded as log2 of the byte count
   typedef enum logic [2:0] {
      SIZE_1  = 3'd0,
      SIZE_2  = 3'd1,
      SIZE_4  = 3'd2,
      SIZE_8  = 3'd3,
      SIZE_16 = 3'd4
   } access_size_t;

   // processor request, wdata is low-aligned
   typedef struct packed {
      logic                  write;
      cache_geom_pkg::addr_t addr;
      access_size_t          size;
      cache_geom_pkg::line_t wdata;
   } cpu_req_t;

   // read data comes back with the addressed byte in byte 0
   typedef struct packed {
      cache_geom_pkg::line_t rdata;
   } cpu_resp_t;

   // line-wide memory bus, low offset bits of line_addr are zero
   typedef struct packed {
      logic                  write;
      cache_geom_pkg::addr_t line_addr;
      cache_geom_pkg::line_t wdata;
   } mem_req_t;

endpackage

`default_nettype wire

//--- hdl/byte_aligner.sv
`timescale 1ns/1ps
`default_nettype none

module byte_aligner (
   input  cache_geom_pkg::offset_t     offset,
   input  cache_bus_pkg::access_size_t size,
   input  cache_geom_pkg::line_t       cpu_wdata,
   input  cache_geom_pkg::line_t       line_rdata,
   output cache_geom_pkg::byte_mask_t  byte_mask,
   output cache_geom_pkg::line_t       wdata_shifted,
   output cache_geom_pkg::line_t       rdata_aligned
);
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;

   byte_mask_t         run;
   logic [OFFSET_W+2:0] bit_shift;

   // low run of ones, one per byte of the access
   always_comb
   begin
      case (size)
         SIZE_1:  run = 16'h0001;
         SIZE_2:  run = 16'h0003;
         SIZE_4:  run = 16'h000f;
         SIZE_8:  run = 16'h00ff;
         SIZE_16: run = 16'hffff;
         default: run = 16'h0000;
      endcase
   end

   // lanes pushed past 15 fall off the top
   assign byte_mask = run << offset;

   // byte offset as a bit count
   assign bit_shift = {offset, 3'b000};

   // write data moved up to its lanes
   assign wdata_shifted = cpu_wdata << bit_shift;

   // addressed byte brought down to byte 0, zeros above
   assign rdata_aligned = line_rdata >> bit_shift;

endmodule

`default_nettype wire

//--- hdl/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store (
   input  wire                        clk,
   input  cache_geom_pkg::index_t     index,
   input  cache_geom_pkg::byte_mask_t data_we,
   input  cache_geom_pkg::line_t      data_wdata,
   output cache_geom_pkg::line_t      line_rdata
);
   import cache_geom_pkg::*;

   line_t lines [NUM_LINES];

   // byte lanes written independently
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < LINE_BYTES; b++)
      begin
         if (data_we[b])
         begin
            lines[index][b*8 +: 8] <= data_wdata[b*8 +: 8];
         end
      end
   end

   // read path, no latency
   assign line_rdata = lines[index];

endmodule

`default_nettype wire

//--- hdl/tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store (
   input  wire                    clk,
   input  wire                    arst_n,
   input  cache_geom_pkg::index_t index,
   input  cache_geom_pkg::tag_t   tag,
   input  wire                    tag_we,
   input  wire                    dirty_in,
   output logic                   hit,
   output logic                   victim_dirty,
   output cache_geom_pkg::tag_t   victim_tag
);
   import cache_geom_pkg::*;

   logic [NUM_LINES-1:0] valid;
   logic [NUM_LINES-1:0] dirty;
   tag_t                 tags [NUM_LINES];

   // status bits per line
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         valid <= '0;
         dirty <= '0;
      end
      else if (tag_we)
      begin
         valid[index] <= 1'b1;
         dirty[index] <= dirty_in;
      end
   end

   // tag bits
   always_ff @(posedge clk)
   begin
      if (tag_we)
      begin
         tags[index] <= tag;
      end
   end

   // combinational lookup of the indexed entry
   always_comb
   begin
      victim_tag   = tags[index];
      hit          = valid[index] && (tags[index] == tag);
      victim_dirty = valid[index] && dirty[index];
   end

endmodule

`default_nettype wire

//--- hdl/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
   input  wire                          clk,
   input  wire                          arst_n,
   // processor side
   input  wire                          req_valid,
   input  cache_bus_pkg::cpu_req_t       req,
   output logic                         req_ready,
   output logic                         resp_valid,
   output cache_bus_pkg::cpu_resp_t      resp,
   // memory bus
   output logic                         mem_valid,
   output cache_bus_pkg::mem_req_t       mem_req,
   input  wire                          mem_ready,
   input  cache_geom_pkg::line_t        mem_rdata,
   // tag store
   output cache_geom_pkg::index_t       index,
   output cache_geom_pkg::tag_t         tag,
   input  wire                          hit,
   input  wire                          victim_dirty,
   input  cache_geom_pkg::tag_t         victim_tag,
   output logic                         tag_we,
   output logic                         dirty_in,
   // byte aligner
   output cache_geom_pkg::offset_t      offset,
   output cache_bus_pkg::access_size_t  size,
   output cache_geom_pkg::line_t        cpu_wdata,
   input  cache_geom_pkg::byte_mask_t   byte_mask,
   input  cache_geom_pkg::line_t        wdata_shifted,
   input  cache_geom_pkg::line_t        rdata_aligned,
   // data store
   input  cache_geom_pkg::line_t        line_rdata,
   output cache_geom_pkg::byte_mask_t   data_we,
   output cache_geom_pkg::line_t        data_wdata
);
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      EVICT,
      FILL,
      HIT
   } state_t;

   state_t   state;
   state_t   state_next;
   cpu_req_t req_q;

   // request is held until the response goes out
   always_ff @(posedge clk)
   begin
      if (req_valid && req_ready)
      begin
         req_q <= req;
      end
   end

   assign tag       = req_q.addr[ADDR_W-1 -: TAG_W];
   assign index     = req_q.addr[OFFSET_W +: INDEX_W];
   assign offset    = req_q.addr[OFFSET_W-1:0];
   assign size      = req_q.size;
   assign cpu_wdata = req_q.wdata;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state <= IDLE;
      end
      else
      begin
         state <= state_next;
      end
   end

   always_comb
   begin
      state_next = state;
      case (state)
         IDLE:
            if (req_valid)
               state_next = LOOKUP;
         LOOKUP:
            if (hit)
               state_next = HIT;
            else if (victim_dirty)
               state_next = EVICT;
            else
               state_next = FILL;
         // bus transfers finish on mem_ready
         EVICT:
            if (mem_ready)
               state_next = FILL;
         FILL:
            if (mem_ready)
               state_next = HIT;
         HIT:
            state_next = IDLE;
         default:
            state_next = IDLE;
      endcase
   end

   assign req_ready = (state == IDLE);

   // bus request, held steady for the whole transfer
   assign mem_valid = (state == EVICT) || (state == FILL);

   always_comb
   begin
      mem_req.write = (state == EVICT);
      if (state == EVICT)
         mem_req.line_addr = {victim_tag, index, {OFFSET_W{1'b0}}};
      else
         mem_req.line_addr = {tag, index, {OFFSET_W{1'b0}}};
      mem_req.wdata = line_rdata;
   end

   // array and tag updates
   always_comb
   begin
      data_we    = '0;
      data_wdata = wdata_shifted;
      tag_we     = 1'b0;
      dirty_in   = 1'b0;
      if (state == FILL && mem_ready)
      begin
         // whole line from memory, clean
         data_we    = '1;
         data_wdata = mem_rdata;
         tag_we     = 1'b1;
      end
      else if (state == HIT && req_q.write)
      begin
         data_we  = byte_mask;
         tag_we   = 1'b1;
         dirty_in = 1'b1;
      end
   end

   // response pulse, one cycle after HIT
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         resp_valid <= 1'b0;
      end
      else
      begin
         resp_valid <= (state == HIT);
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == HIT)
      begin
         resp.rdata <= rdata_aligned;
      end
   end

endmodule

`default_nettype wire

//--- hdl/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     req_valid,
   input  cache_bus_pkg::cpu_req_t  req,
   output logic                    req_ready,
   output logic                    resp_valid,
   output cache_bus_pkg::cpu_resp_t resp,
   output logic                    mem_valid,
   output cache_bus_pkg::mem_req_t  mem_req,
   input  wire                     mem_ready,
   input  cache_geom_pkg::line_t   mem_rdata
);
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;

   // controller to tag store
   index_t index;
   tag_t   tag;
   logic   hit;
   logic   victim_dirty;
   tag_t   victim_tag;
   logic   tag_we;
   logic   dirty_in;

   // controller to byte aligner
   offset_t      offset;
   access_size_t size;
   line_t        cpu_wdata;
   byte_mask_t   byte_mask;
   line_t        wdata_shifted;
   line_t        rdata_aligned;

   // data array
   byte_mask_t data_we;
   line_t      data_wdata;
   line_t      line_rdata;

   cache_ctrl u_ctrl (
      .clk           (clk),
      .arst_n        (arst_n),
      .req_valid     (req_valid),
      .req           (req),
      .req_ready     (req_ready),
      .resp_valid    (resp_valid),
      .resp          (resp),
      .mem_valid     (mem_valid),
      .mem_req       (mem_req),
      .mem_ready     (mem_ready),
      .mem_rdata     (mem_rdata),
      .index         (index),
      .tag           (tag),
      .hit           (hit),
      .victim_dirty  (victim_dirty),
      .victim_tag    (victim_tag),
      .tag_we        (tag_we),
      .dirty_in      (dirty_in),
      .offset        (offset),
      .size          (size),
      .cpu_wdata     (cpu_wdata),
      .byte_mask     (byte_mask),
      .wdata_shifted (wdata_shifted),
      .rdata_aligned (rdata_aligned),
      .line_rdata    (line_rdata),
      .data_we       (data_we),
      .data_wdata    (data_wdata)
   );

   tag_store u_tags (
      .clk          (clk),
      .arst_n       (arst_n),
      .index        (index),
      .tag          (tag),
      .tag_we       (tag_we),
      .dirty_in     (dirty_in),
      .hit          (hit),
      .victim_dirty (victim_dirty),
      .victim_tag   (victim_tag)
   );

   data_store u_data (
      .clk        (clk),
      .index      (index),
      .data_we    (data_we),
      .data_wdata (data_wdata),
      .line_rdata (line_rdata)
   );

   byte_aligner u_align (
      .offset        (offset),
      .size          (size),
      .cpu_wdata     (cpu_wdata),
      .line_rdata    (line_rdata),
      .byte_mask     (byte_mask),
      .wdata_shifted (wdata_shifted),
      .rdata_aligned (rdata_aligned)
   );

endmodule

`default_nettype wire

//--- tb/tb_cache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_sva (
   input wire                     clk,
   input wire                     arst_n,
   input wire                     req_valid,
   input wire                     req_ready,
   input wire                     resp_valid,
   input wire                     mem_valid,
   input wire                     mem_ready,
   input cache_bus_pkg::mem_req_t mem_req
);
   int   sva_errors = 0;
   logic busy;

   // request in flight from acceptance until its response
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         busy <= 1'b0;
      else if (req_valid && req_ready)
         busy <= 1'b1;
      else if (resp_valid)
         busy <= 1'b0;
   end

   // bus request frozen while memory stalls
   mem_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
   else
   begin
      $error("mem_req changed during a stalled transfer");
      sva_errors++;
   end

   resp_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      resp_valid |=> !resp_valid)
   else
   begin
      $error("resp_valid held longer than one cycle");
      sva_errors++;
   end

   // no second request taken while one is outstanding
   ready_low_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
      busy && !resp_valid |-> !req_ready)
   else
   begin
      $error("req_ready high while a request is outstanding");
      sva_errors++;
   end

   // handshake outputs while reset is held
   reset_values: assert property (@(posedge clk)
      !arst_n |-> req_ready && !resp_valid && !mem_valid)
   else
   begin
      $error("wrong handshake values during reset");
      sva_errors++;
   end

endmodule

bind cache_ctrl tb_cache_sva u_sva (
   .clk        (clk),
   .arst_n     (arst_n),
   .req_valid  (req_valid),
   .req_ready  (req_ready),
   .resp_valid (resp_valid),
   .mem_valid  (mem_valid),
   .mem_ready  (mem_ready),
   .mem_req    (mem_req)
);

`default_nettype wire

//--- tb/tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;

   localparam int MEM_LINES = 4096;
   localparam int TIMEOUT   = 200;

   logic      clk;
   logic      arst_n;
   logic      req_valid;
   cpu_req_t  req;
   logic      req_ready;
   logic      resp_valid;
   cpu_resp_t resp;
   logic      mem_valid;
   mem_req_t  mem_req;
   logic      mem_ready;
   line_t     mem_rdata;

   line_t      mem_lines [MEM_LINES];
   logic [7:0] shadow [65536];
   int         seed = 32'hef2f_7952;
   int         err_cnt = 0;
   int         tests_run = 0;
   int         tests_failed = 0;
   logic       timed_out = 1'b0;
   // bus transfers seen by the memory model
   logic       log_write [$];
   addr_t      log_addr [$];
   line_t      log_data [$];

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   cache_top i_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .mem_valid  (mem_valid),
      .mem_req    (mem_req),
      .mem_ready  (mem_ready),
      .mem_rdata  (mem_rdata)
   );

   function automatic int rand_below(int n);
      return int'({$random(seed)} % n);
   endfunction

   function automatic line_t random_line();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   function automatic int size_bytes(access_size_t size);
      case (size)
         SIZE_1:  return 1;
         SIZE_2:  return 2;
         SIZE_4:  return 4;
         SIZE_8:  return 8;
         default: return 16;
      endcase
   endfunction

   function automatic void check(bit ok, string what);
      assert (ok)
      else
      begin
         $display("FAILED at %0t: %s", $time, what);
         err_cnt++;
      end
   endfunction

   // bytes from the offset to the line end, zeros above
   function automatic line_t expected_read(addr_t addr);
      line_t exp_line;
      addr_t base;
      int    off;
      exp_line = '0;
      base     = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
      off      = int'(addr[OFFSET_W-1:0]);
      for (int k = LINE_BYTES - 1; k >= 0; k--)
      begin
         exp_line = exp_line << 8;
         if (off + k < LINE_BYTES)
            exp_line[7:0] = shadow[base + addr_t'(off + k)];
      end
      return exp_line;
   endfunction

   function automatic void apply_write(addr_t addr, access_size_t size, line_t wdata);
      for (int k = 0; k < size_bytes(size); k++)
         if (int'(addr[OFFSET_W-1:0]) + k < LINE_BYTES)
            shadow[addr + addr_t'(k)] = 8'(wdata >> (8 * k));
   endfunction

   function automatic void clear_log();
      log_write.delete();
      log_addr.delete();
      log_data.delete();
   endfunction

   function automatic void report_test(string name, int errs_before);
      tests_run++;
      if (err_cnt != errs_before || timed_out)
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, err_cnt - errs_before);
      end
      else
         $display("test %s: ok", name);
   endfunction

   // memory behind the bus, ready after 0 to 3 idle cycles
   initial
   begin : memory_model
      int          delay;
      logic [11:0] line_idx;
      mem_req_t    cur;
      mem_ready <= 1'b0;
      mem_rdata <= '0;
      for (int i = 0; i < MEM_LINES; i++)
         mem_lines[12'(i)] = random_line();
      forever
      begin
         @(negedge clk);
         if (mem_valid)
         begin
            cur      = mem_req;
            line_idx = cur.line_addr[ADDR_W-1:OFFSET_W];
            delay    = rand_below(4);
            log_write.push_back(cur.write);
            log_addr.push_back(cur.line_addr);
            log_data.push_back(cur.wdata);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            mem_ready <= 1'b1;
            mem_rdata <= mem_lines[line_idx];
            @(posedge clk);
            mem_ready <= 1'b0;
            if (cur.write)
               mem_lines[line_idx] = cur.wdata;
         end
      end
   end

   // one processor access, latency counted in cycles after acceptance
   task automatic do_access(input logic write, input addr_t addr, input access_size_t size,
                            input line_t wdata, output int latency);
      cpu_req_t r;
      line_t    expected;
      int       waited;
      r.write  = write;
      r.addr   = addr;
      r.size   = size;
      r.wdata  = wdata;
      expected = expected_read(addr);
      latency  = 0;
      waited   = 0;
      if (timed_out)
         return;
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= r;
      do
      begin
         @(negedge clk);
         waited++;
      end
      while (!req_ready && waited < TIMEOUT);
      if (!req_ready)
      begin
         $display("timeout: request to %h was never accepted", addr);
         timed_out = 1'b1;
         return;
      end
      @(posedge clk);
      req_valid <= 1'b0;
      waited = 0;
      do
      begin
         @(posedge clk);
         @(negedge clk);
         waited++;
      end
      while (!resp_valid && waited < TIMEOUT);
      if (!resp_valid)
      begin
         $display("timeout: no response for the access to %h", addr);
         timed_out = 1'b1;
         return;
      end
      latency = waited;
      if (write)
         apply_write(addr, size, wdata);
      else
         check(resp.rdata == expected, $sformatf("read %h got %h, expected %h",
                                                 addr, resp.rdata, expected));
   endtask

   task automatic test_reset();
      int errs_before;
      errs_before = err_cnt;
      @(negedge clk);
      check(req_ready === 1'b1, "req_ready not high after reset");
      check(resp_valid === 1'b0, "resp_valid not low after reset");
      check(mem_valid === 1'b0, "mem_valid not low after reset");
      report_test("reset state", errs_before);
   endtask

   task automatic test_read_miss();
      int errs_before;
      int lat;
      errs_before = err_cnt;
      clear_log();
      do_access(1'b0, 16'h1234, SIZE_4, '0, lat);
      check(log_addr.size() == 1, $sformatf("%0d bus transfers on a miss", log_addr.size()));
      if (log_addr.size() == 1)
         check(!log_write[0] && log_addr[0] == 16'h1230, "wrong bus read on a miss");
      clear_log();
      do_access(1'b0, 16'h1234, SIZE_4, '0, lat);
      check(lat == 2, $sformatf("hit latency %0d, expected 2", lat));
      check(log_addr.size() == 0, "bus transfer on a hit");
      report_test("read miss", errs_before);
   endtask

   // write, then read the whole line and the written bytes back
   task automatic write_and_check(input addr_t addr, input access_size_t size);
      int lat;
      do_access(1'b1, addr, size, random_line(), lat);
      do_access(1'b0, {addr[ADDR_W-1:OFFSET_W], 4'h0}, SIZE_16, '0, lat);
      do_access(1'b0, addr, size, '0, lat);
   endtask

   task automatic test_write_sizes();
      int errs_before;
      errs_before = err_cnt;
      write_and_check(16'h2a43, SIZE_1);
      write_and_check(16'h2a46, SIZE_2);
      write_and_check(16'h2a4c, SIZE_4);
      write_and_check(16'h2a48, SIZE_8);
      write_and_check(16'h2a40, SIZE_16);
      report_test("write sizes", errs_before);
   endtask

   task automatic test_dirty_evict();
      int    errs_before;
      int    lat;
      line_t old_line;
      errs_before = err_cnt;
      // same index 5, tags 0x2d and 0x0d
      do_access(1'b1, 16'h5a54, SIZE_4, random_line(), lat);
      old_line = expected_read(16'h5a50);
      clear_log();
      do_access(1'b0, 16'h1a50, SIZE_16, '0, lat);
      check(log_addr.size() == 2, $sformatf("%0d bus transfers, expected 2", log_addr.size()));
      if (log_addr.size() == 2)
      begin
         check(log_write[0] && log_addr[0] == 16'h5a50, "no write-back to the old line");
         check(log_data[0] == old_line, $sformatf("write-back data %h, expected %h",
                                                  log_data[0], old_line));
         check(!log_write[1] && log_addr[1] == 16'h1a50, "fill after write-back is wrong");
      end
      do_access(1'b0, 16'h5a50, SIZE_16, '0, lat);
      report_test("dirty eviction", errs_before);
   endtask

   task automatic test_clean_evict();
      int errs_before;
      int lat;
      errs_before = err_cnt;
      do_access(1'b0, 16'h0c60, SIZE_8, '0, lat);
      clear_log();
      do_access(1'b0, 16'h7c68, SIZE_8, '0, lat);
      check(log_addr.size() == 1, $sformatf("%0d bus transfers, expected 1", log_addr.size()));
      if (log_addr.size() == 1)
         check(!log_write[0] && log_addr[0] == 16'h7c60, "clean eviction wrote to memory");
      report_test("clean eviction", errs_before);
   endtask

   task automatic test_random_mix();
      int           errs_before;
      int           lat;
      access_size_t size;
      addr_t        addr;
      errs_before = err_cnt;
      for (int i = 0; i < 40; i++)
      begin
         size = access_size_t'(rand_below(5));
         // four tags on two indices keep lines conflicting
         addr = {tag_t'(rand_below(4)), index_t'(8 + rand_below(2)),
                 offset_t'(rand_below(LINE_BYTES / size_bytes(size)) * size_bytes(size))};
         do_access(rand_below(2) == 1, addr, size, random_line(), lat);
      end
      report_test("memory stalls", errs_before);
   endtask

   initial
   begin
      arst_n    <= 1'b0;
      req_valid <= 1'b0;
      req       <= '0;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      for (int a = 0; a < 65536; a++)
         shadow[16'(a)] = 8'(mem_lines[12'(a / 16)] >> (8 * (a % 16)));
      test_reset();
      if (!timed_out)
         test_read_miss();
      if (!timed_out)
         test_write_sizes();
      if (!timed_out)
         test_dirty_evict();
      if (!timed_out)
         test_clean_evict();
      if (!timed_out)
         test_random_mix();
      $display("tests run: %0d, tests failed: %0d, check errors: %0d, assertion errors: %0d",
               tests_run, tests_failed, err_cnt, i_dut.u_ctrl.u_sva.sva_errors);
      if (err_cnt == 0 && !timed_out && i_dut.u_ctrl.u_sva.sva_errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
hdl/cache_geom_pkg.sv
hdl/cache_bus_pkg.sv
hdl/byte_aligner.sv
hdl/data_store.sv
hdl/tag_store.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
tb/tb_cache_sva.sv
tb/tb_cache.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_cache \
   -f all.f \
   -o sim_cache

# keep running after an assertion fires so the closing summary is printed
./obj_dir/sim_cache +verilator+error+limit+1000 | tee sim.log

if grep -q "FAIL: see errors above" sim.log
then
   echo "simulation failed"
   exit 1
fi

echo "simulation passed"
